// File: tb.f
rtl/hit_pkg.sv
rtl/sync_fifo.sv
rtl/edge_test.sv
rtl/hit_bool.sv
rtl/hit_top.sv
dv/hit_asserts.sv
dv/hit_tb.sv

// File: Makefile
# Verilator flow for the point-in-triangle testbench

VERILATOR  ?= verilator
TOP        ?= hit_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= Regression passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv) $(wildcard dv/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Status comes from the search for the pass line
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/hit_tb.sv
module hit_tb;

    localparam int pair_count   = 300;
    localparam int send_limit   = 200;
    localparam int fill_limit   = 100;
    localparam int drain_limit  = 1000;
    localparam int quiet_cycles = 8;

    logic                 clock;
    logic                 reset;
    hit_pkg::tri_t        tri_din;
    logic                 tri_wr_en;
    logic                 tri_full;
    hit_pkg::vec3_t       p_hit_din;
    logic                 p_hit_wr_en;
    logic                 p_hit_full;
    hit_pkg::hit_result_t result_dout;
    logic                 result_empty;
    logic                 result_rd_en;

    integer seed = 76958;

    // Accepted inputs waiting for their result, paired by position
    hit_pkg::tri_t  tri_q[$];
    hit_pkg::vec3_t pt_q[$];

    int results_read = 0;

    // 0 holds reads off, 1 reads every cycle, 2 reads with random gaps
    int read_mode = 0;

    hit_top hit_top_inst (
        .clock        (clock),
        .reset        (reset),
        .tri_din      (tri_din),
        .tri_wr_en    (tri_wr_en),
        .tri_full     (tri_full),
        .p_hit_din    (p_hit_din),
        .p_hit_wr_en  (p_hit_wr_en),
        .p_hit_full   (p_hit_full),
        .result_dout  (result_dout),
        .result_empty (result_empty),
        .result_rd_en (result_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Q10 multiply with a 64-bit product, result wraps to 32 bits
    function automatic int fx_mul(input int a, input int b);
        longint prod;
        prod = longint'(a) * longint'(b);
        return int'(prod >>> hit_pkg::q_bits);
    endfunction

    function automatic hit_pkg::vec3_t vec_sub(input hit_pkg::vec3_t a, input hit_pkg::vec3_t b);
        hit_pkg::vec3_t r;
        r.x = a.x - b.x;
        r.y = a.y - b.y;
        r.z = a.z - b.z;
        return r;
    endfunction

    function automatic hit_pkg::vec3_t cross_q(input hit_pkg::vec3_t a, input hit_pkg::vec3_t b);
        hit_pkg::vec3_t c;
        c.x = fx_mul(a.y, b.z) - fx_mul(a.z, b.y);
        c.y = fx_mul(a.z, b.x) - fx_mul(a.x, b.z);
        c.z = fx_mul(a.x, b.y) - fx_mul(a.y, b.x);
        return c;
    endfunction

    function automatic int dot_q(input hit_pkg::vec3_t a, input hit_pkg::vec3_t b);
        return fx_mul(a.x, b.x) + fx_mul(a.y, b.y) + fx_mul(a.z, b.z);
    endfunction

    // Signed distance-like value of the point against one edge
    function automatic int edge_side(input hit_pkg::vec3_t va, input hit_pkg::vec3_t vb,
                                     input hit_pkg::vec3_t p, input hit_pkg::vec3_t n);
        return dot_q(n, cross_q(vec_sub(vb, va), vec_sub(p, va)));
    endfunction

    function automatic logic expected_hit(input hit_pkg::tri_t t, input hit_pkg::vec3_t p);
        int d0;
        int d1;
        int d2;
        d0 = edge_side(t.v0, t.v1, p, t.normal);
        d1 = edge_side(t.v1, t.v2, p, t.normal);
        d2 = edge_side(t.v2, t.v0, p, t.normal);
        return (d0 > 0) && (d1 > 0) && (d2 > 0);
    endfunction

    // About +-16.0 in Q10
    function automatic int rand_coord();
        return $random(seed) % 16384;
    endfunction

    function automatic hit_pkg::vec3_t rand_vec();
        hit_pkg::vec3_t v;
        v.x = rand_coord();
        v.y = rand_coord();
        v.z = rand_coord();
        return v;
    endfunction

    // Scaled down so the dot products stay far from wrapping
    function automatic hit_pkg::vec3_t face_normal(input hit_pkg::tri_t t);
        hit_pkg::vec3_t c;
        hit_pkg::vec3_t n;
        c = cross_q(vec_sub(t.v1, t.v0), vec_sub(t.v2, t.v0));
        n.x = c.x >>> 8;
        n.y = c.y >>> 8;
        n.z = c.z >>> 8;
        return n;
    endfunction

    function automatic hit_pkg::tri_t make_triangle();
        hit_pkg::tri_t t;
        t.v0 = rand_vec();
        t.v1 = rand_vec();
        t.v2 = rand_vec();
        // Roughly one in sixteen is degenerate
        if (($random(seed) & 15) == 0) begin
            t.normal = '0;
        end else begin
            t.normal = face_normal(t);
        end
        return t;
    endfunction

    // Inside points are a positive weighted average of the vertices
    function automatic hit_pkg::vec3_t make_point(input hit_pkg::tri_t t, input logic want_in);
        hit_pkg::vec3_t p;
        longint w0;
        longint w1;
        longint w2;
        longint wsum;
        if (!want_in) begin
            return rand_vec();
        end
        w0 = longint'(1 + ($random(seed) & 63));
        w1 = longint'(1 + ($random(seed) & 63));
        w2 = longint'(1 + ($random(seed) & 63));
        wsum = w0 + w1 + w2;
        p.x = int'((w0 * t.v0.x + w1 * t.v1.x + w2 * t.v2.x) / wsum);
        p.y = int'((w0 * t.v0.y + w1 * t.v1.y + w2 * t.v2.y) / wsum);
        p.z = int'((w0 * t.v0.z + w1 * t.v1.z + w2 * t.v2.z) / wsum);
        return p;
    endfunction

    task automatic offer_inputs(input logic do_tri, input hit_pkg::tri_t t,
                                input logic do_pt, input hit_pkg::vec3_t p,
                                output logic tri_ok, output logic pt_ok);
        @(posedge clock);
        tri_din     <= t;
        tri_wr_en   <= do_tri;
        p_hit_din   <= p;
        p_hit_wr_en <= do_pt;
        // Full seen here decides whether the coming edge takes the write
        @(negedge clock);
        tri_ok = do_tri && !tri_full;
        pt_ok  = do_pt && !p_hit_full;
        if (tri_ok) begin
            tri_q.push_back(t);
        end
        if (pt_ok) begin
            pt_q.push_back(p);
        end
    endtask

    // Retries only the side that was refused
    task automatic send_inputs(input logic do_tri, input hit_pkg::tri_t t,
                               input logic do_pt, input hit_pkg::vec3_t p);
        int   tries;
        logic tri_left;
        logic pt_left;
        logic tri_ok;
        logic pt_ok;
        tries    = 0;
        tri_left = do_tri;
        pt_left  = do_pt;
        while (tri_left || pt_left) begin
            if (tries == send_limit) begin
                $display("Timeout: an input FIFO stayed full while sending");
                abort_run();
            end
            offer_inputs(tri_left, t, pt_left, p, tri_ok, pt_ok);
            tri_left = tri_left && !tri_ok;
            pt_left  = pt_left && !pt_ok;
            tries++;
        end
    endtask

    task automatic idle_inputs();
        @(posedge clock);
        tri_wr_en   <= 1'b0;
        p_hit_wr_en <= 1'b0;
    endtask

    // Waits for the result count to reach target, then watches for extras
    task automatic wait_results(input int target);
        int cycles;
        cycles = 0;
        while (results_read < target) begin
            if (cycles == drain_limit) begin
                $display("Timeout: results stopped arriving with pairs still outstanding");
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
        repeat (quiet_cycles) begin
            @(negedge clock);
            check_value("result_empty", 128'(result_empty), 128'(1));
        end
        check_value("results read", 128'(results_read), 128'(target));
    endtask

    task automatic check_result(input hit_pkg::hit_result_t r);
        hit_pkg::tri_t  t;
        hit_pkg::vec3_t p;
        if (tri_q.size() == 0 || pt_q.size() == 0) begin
            $display("A result came out with no triangle and hit point pair sent for it");
            abort_run();
        end
        t = tri_q.pop_front();
        p = pt_q.pop_front();
        check_value("result_dout.hit", 128'(r.hit), 128'(expected_hit(t, p)));
        check_value("result_dout.p_hit", 128'(r.p_hit), 128'(p));
        results_read++;
    endtask

    initial begin : result_reader
        logic want_read;
        result_rd_en = 1'b0;
        forever begin
            @(posedge clock);
            if (read_mode == 0) begin
                want_read = 1'b0;
            end else if (read_mode == 1) begin
                want_read = 1'b1;
            end else begin
                want_read = ($random(seed) & 3) != 0;
            end
            result_rd_en <= want_read;
            // Head is stable mid-cycle and is popped on the next edge
            @(negedge clock);
            if (result_rd_en && !result_empty) begin
                check_result(result_dout);
            end
        end
    end

    initial begin : main_sequence
        hit_pkg::tri_t  t;
        hit_pkg::vec3_t p;
        hit_pkg::tri_t  held[4];
        logic           tri_ok;
        logic           pt_ok;
        logic           full_seen;
        int             sent;
        int             start_count;
        int             tries;
        reset       = 1'b1;
        tri_din     = '0;
        tri_wr_en   = 1'b0;
        p_hit_din   = '0;
        p_hit_wr_en = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("result_empty", 128'(result_empty), 128'(1));
        check_value("tri_full", 128'(tri_full), 128'(0));
        check_value("p_hit_full", 128'(p_hit_full), 128'(0));

        // Random pairs, half with the point built inside the triangle
        for (int i = 0; i < pair_count; i++) begin
            read_mode = (i < pair_count / 2) ? 1 : 2;
            if (($random(seed) & 7) == 0) begin
                idle_inputs();
            end
            t = make_triangle();
            p = make_point(t, ($random(seed) & 1) == 1);
            send_inputs(1'b1, t, 1'b1, p);
        end
        idle_inputs();
        wait_results(pair_count);

        // Triangles alone must not produce anything
        read_mode   = 1;
        start_count = results_read;
        for (int i = 0; i < 4; i++) begin
            held[i] = make_triangle();
            send_inputs(1'b1, held[i], 1'b0, p);
        end
        idle_inputs();
        repeat (20) begin
            @(negedge clock);
            check_value("result_empty", 128'(result_empty), 128'(1));
        end
        for (int i = 0; i < 4; i++) begin
            send_inputs(1'b0, held[i], 1'b1, make_point(held[i], i[0]));
        end
        idle_inputs();
        wait_results(start_count + 4);

        // Back-pressure until an input FIFO reports full
        read_mode   = 0;
        sent        = 0;
        tries       = 0;
        full_seen   = 1'b0;
        start_count = results_read;
        while (!full_seen) begin
            if (tries == fill_limit) begin
                $display("Timeout: input FIFOs never filled while results were held");
                abort_run();
            end
            t = make_triangle();
            p = make_point(t, ($random(seed) & 1) == 1);
            offer_inputs(1'b1, t, 1'b1, p, tri_ok, pt_ok);
            if (tri_ok && pt_ok) begin
                sent++;
            end
            full_seen = tri_full || p_hit_full;
            tries++;
        end
        idle_inputs();
        read_mode = 2;
        wait_results(start_count + sent);

        if (tri_q.size() == 0 && pt_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Inputs left without a result: %0d triangles, %0d hit points",
                     tri_q.size(), pt_q.size());
            abort_run();
        end
    end

endmodule

// File: dv/hit_asserts.sv
module hit_asserts (
    input logic clock,
    input logic reset,
    input logic tri_empty,
    input logic p_hit_empty,
    input logic tri_rd_en,
    input logic p_hit_rd_en,
    input logic result_wr_en,
    input logic result_full
);

    // Result FIFO must never be handed a write it would drop
    write_not_full: assert property (
        @(posedge clock) disable iff (reset) result_wr_en |-> !result_full
    ) else $error("result write while the result FIFO is full");

    read_not_empty: assert property (
        @(posedge clock) disable iff (reset)
        (tri_rd_en || p_hit_rd_en) |-> (!tri_empty && !p_hit_empty)
    ) else $error("input read while an input FIFO is empty");

    // Pairs stay aligned only if both heads pop together
    reads_paired: assert property (
        @(posedge clock) disable iff (reset) tri_rd_en == p_hit_rd_en
    ) else $error("tri_rd_en and p_hit_rd_en differ");

    // Three open edges after a read, its verdict is written
    read_to_write: assert property (
        @(posedge clock) disable iff (reset)
        tri_rd_en ##1 (!result_full) [*3] |-> result_wr_en
    ) else $error("result not written three cycles after its input read");

endmodule

bind hit_bool hit_asserts hit_asserts_inst (
    .clock        (clock),
    .reset        (reset),
    .tri_empty    (tri_empty),
    .p_hit_empty  (p_hit_empty),
    .tri_rd_en    (tri_rd_en),
    .p_hit_rd_en  (p_hit_rd_en),
    .result_wr_en (result_wr_en),
    .result_full  (result_full)
);

// File: rtl/hit_top.sv
module hit_top (
    input  logic                 clock,
    input  logic                 reset,
    input  hit_pkg::tri_t        tri_din,
    input  logic                 tri_wr_en,
    output logic                 tri_full,
    input  hit_pkg::vec3_t       p_hit_din,
    input  logic                 p_hit_wr_en,
    output logic                 p_hit_full,
    output hit_pkg::hit_result_t result_dout,
    output logic                 result_empty,
    input  logic                 result_rd_en
);

    // Triangle FIFO to pipeline
    hit_pkg::tri_t tri_head;
    logic          tri_empty;
    logic          tri_rd_en;

    // Hit-point FIFO to pipeline
    hit_pkg::vec3_t p_hit_head;
    logic           p_hit_empty;
    logic           p_hit_rd_en;

    // Pipeline to result FIFO
    hit_pkg::hit_result_t result_din;
    logic                 result_wr_en;
    logic                 result_full;

    sync_fifo #(
        .width      ($bits(hit_pkg::tri_t)),
        .depth_log2 (hit_pkg::fifo_depth_log2)
    ) tri_fifo_inst (
        .clock (clock),
        .reset (reset),
        .wr_en (tri_wr_en),
        .din   (tri_din),
        .full  (tri_full),
        .rd_en (tri_rd_en),
        .dout  (tri_head),
        .empty (tri_empty)
    );

    sync_fifo #(
        .width      ($bits(hit_pkg::vec3_t)),
        .depth_log2 (hit_pkg::fifo_depth_log2)
    ) p_hit_fifo_inst (
        .clock (clock),
        .reset (reset),
        .wr_en (p_hit_wr_en),
        .din   (p_hit_din),
        .full  (p_hit_full),
        .rd_en (p_hit_rd_en),
        .dout  (p_hit_head),
        .empty (p_hit_empty)
    );

    hit_bool hit_bool_inst (
        .clock        (clock),
        .reset        (reset),
        .tri_head     (tri_head),
        .tri_empty    (tri_empty),
        .tri_rd_en    (tri_rd_en),
        .p_hit_head   (p_hit_head),
        .p_hit_empty  (p_hit_empty),
        .p_hit_rd_en  (p_hit_rd_en),
        .result_din   (result_din),
        .result_wr_en (result_wr_en),
        .result_full  (result_full)
    );

    sync_fifo #(
        .width      ($bits(hit_pkg::hit_result_t)),
        .depth_log2 (hit_pkg::fifo_depth_log2)
    ) result_fifo_inst (
        .clock (clock),
        .reset (reset),
        .wr_en (result_wr_en),
        .din   (result_din),
        .full  (result_full),
        .rd_en (result_rd_en),
        .dout  (result_dout),
        .empty (result_empty)
    );

endmodule

// File: rtl/hit_bool.sv
module hit_bool (
    input  logic                 clock,
    input  logic                 reset,
    input  hit_pkg::tri_t        tri_head,
    input  logic                 tri_empty,
    output logic                 tri_rd_en,
    input  hit_pkg::vec3_t       p_hit_head,
    input  logic                 p_hit_empty,
    output logic                 p_hit_rd_en,
    output hit_pkg::hit_result_t result_din,
    output logic                 result_wr_en,
    input  logic                 result_full
);

    logic advance;
    logic take;

    // One valid bit per pipeline stage
    logic valid_s1;
    logic valid_s2;
    logic valid_s3;

    // Hit point travels alongside its triangle through the stages
    hit_pkg::vec3_t p_hit_s1;
    hit_pkg::vec3_t p_hit_s2;
    hit_pkg::vec3_t p_hit_s3;

    logic signed [hit_pkg::d_bits-1:0] dot0;
    logic signed [hit_pkg::d_bits-1:0] dot1;
    logic signed [hit_pkg::d_bits-1:0] dot2;

    // Only a blocked last stage stalls the pipe
    assign advance = !(valid_s3 && result_full);

    // Both heads are consumed together so pairs never drift apart
    assign take        = advance && !tri_empty && !p_hit_empty;
    assign tri_rd_en   = take;
    assign p_hit_rd_en = take;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
        end else if (advance) begin
            valid_s1 <= take;
            valid_s2 <= valid_s1;
            valid_s3 <= valid_s2;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            p_hit_s1 <= p_hit_head;
            p_hit_s2 <= p_hit_s1;
            p_hit_s3 <= p_hit_s2;
        end
    end

    // Edge v0 -> v1
    edge_test edge0_inst (
        .clock   (clock),
        .reset   (reset),
        .advance (advance),
        .va      (tri_head.v0),
        .vb      (tri_head.v1),
        .p_hit   (p_hit_head),
        .normal  (tri_head.normal),
        .dot     (dot0)
    );

    // Edge v1 -> v2
    edge_test edge1_inst (
        .clock   (clock),
        .reset   (reset),
        .advance (advance),
        .va      (tri_head.v1),
        .vb      (tri_head.v2),
        .p_hit   (p_hit_head),
        .normal  (tri_head.normal),
        .dot     (dot1)
    );

    // Edge v2 -> v0
    edge_test edge2_inst (
        .clock   (clock),
        .reset   (reset),
        .advance (advance),
        .va      (tri_head.v2),
        .vb      (tri_head.v0),
        .p_hit   (p_hit_head),
        .normal  (tri_head.normal),
        .dot     (dot2)
    );

    // Inside only if strictly on the inner side of every edge
    // A zero normal gives zero dots and therefore a miss
    assign result_din.hit   = (dot0 > 0) && (dot1 > 0) && (dot2 > 0);
    assign result_din.p_hit = p_hit_s3;

    assign result_wr_en = valid_s3 && !result_full;

endmodule

// File: rtl/edge_test.sv
module edge_test (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               advance,
    input  hit_pkg::vec3_t                     va,
    input  hit_pkg::vec3_t                     vb,
    input  hit_pkg::vec3_t                     p_hit,
    input  hit_pkg::vec3_t                     normal,
    output logic signed [hit_pkg::d_bits-1:0]  dot
);

    // Fixed-point multiply: full 64-bit product, renormalised and truncated
    function automatic logic signed [hit_pkg::d_bits-1:0] q_mul(
        input logic signed [hit_pkg::d_bits-1:0] a,
        input logic signed [hit_pkg::d_bits-1:0] b
    );
        logic signed [2*hit_pkg::d_bits-1:0] prod;
        logic signed [2*hit_pkg::d_bits-1:0] scaled;
        prod   = a * b;
        scaled = prod >>> hit_pkg::q_bits;
        return scaled[hit_pkg::d_bits-1:0];
    endfunction

    // Stage 1 outputs
    hit_pkg::vec3_t edge_vec;
    hit_pkg::vec3_t point_vec;
    hit_pkg::vec3_t normal_s1;

    // Stage 2 outputs
    hit_pkg::vec3_t cross_vec;
    hit_pkg::vec3_t normal_s2;

    // Stage 1, edge and point vectors relative to the start vertex
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            edge_vec  <= '0;
            point_vec <= '0;
            normal_s1 <= '0;
        end else if (advance) begin
            edge_vec.x  <= vb.x - va.x;
            edge_vec.y  <= vb.y - va.y;
            edge_vec.z  <= vb.z - va.z;
            point_vec.x <= p_hit.x - va.x;
            point_vec.y <= p_hit.y - va.y;
            point_vec.z <= p_hit.z - va.z;
            normal_s1   <= normal;
        end
    end

    // Stage 2, edge x point
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cross_vec <= '0;
            normal_s2 <= '0;
        end else if (advance) begin
            cross_vec.x <= q_mul(edge_vec.y, point_vec.z) - q_mul(edge_vec.z, point_vec.y);
            cross_vec.y <= q_mul(edge_vec.z, point_vec.x) - q_mul(edge_vec.x, point_vec.z);
            cross_vec.z <= q_mul(edge_vec.x, point_vec.y) - q_mul(edge_vec.y, point_vec.x);
            normal_s2   <= normal_s1;
        end
    end

    // Stage 3, projection onto the face normal
    // Sign says which side of the edge the point lies on
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dot <= '0;
        end else if (advance) begin
            dot <= q_mul(normal_s2.x, cross_vec.x) +
                   q_mul(normal_s2.y, cross_vec.y) +
                   q_mul(normal_s2.z, cross_vec.z);
        end
    end

endmodule

// File: rtl/sync_fifo.sv
module sync_fifo #(
    parameter int width      = 32,
    parameter int depth_log2 = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [width-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             empty
);

    // Storage, no reset needed since empty masks stale entries
    logic [width-1:0] mem [1 << depth_log2];

    // Extra MSB on each pointer tells full from empty
    logic [depth_log2:0] wr_ptr;
    logic [depth_log2:0] rd_ptr;

    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[depth_log2] != rd_ptr[depth_log2]) &&
                   (wr_ptr[depth_log2-1:0] == rd_ptr[depth_log2-1:0]);

    // Writes to a full FIFO and reads from an empty one are dropped
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // Head entry is always visible (first-word fall-through)
    assign dout = mem[rd_ptr[depth_log2-1:0]];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[depth_log2-1:0]] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: rtl/hit_pkg.sv
package hit_pkg;

    // Signed Q10 fixed point, 32-bit words
    localparam int d_bits = 32;
    localparam int q_bits = 10;

    // Every FIFO in the design is 16 entries deep
    localparam int fifo_depth_log2 = 4;

    // One point or direction in 3D space
    typedef struct packed {
        logic signed [d_bits-1:0] x;
        logic signed [d_bits-1:0] y;
        logic signed [d_bits-1:0] z;
    } vec3_t;

    // Triangle as it sits in the input FIFO
    // Normal travels with its vertices so they stay paired
    typedef struct packed {
        vec3_t v0;
        vec3_t v1;
        vec3_t v2;
        vec3_t normal;
    } tri_t;

    // Verdict plus the hit point it was computed for
    typedef struct packed {
        logic  hit;
        vec3_t p_hit;
    } hit_result_t;

endpackage
